//--- cluster_pkg.sv
/*
 * TCDM cluster package: sizes, request and response structs,
 * and the link direction enum shared by router and bank
 */
package cluster_pkg;

  localparam int unsigned NumGroups = 4;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned TagWidth  = 4;

  typedef logic [$clog2(NumGroups)-1:0] group_id_t;

  // Word address; the low two bits select the owning group
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 wen;
    logic [DataWidth-1:0] wdata;
    group_id_t            src;
    logic [TagWidth-1:0]  tag;
  } tcdm_req_t;

  // Old word is returned on a write
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 wen;
    group_id_t            src;
    logic [TagWidth-1:0]  tag;
  } tcdm_resp_t;

  // Direction = target group XOR own group
  typedef enum logic [1:0] {
    PortLocal     = 2'd0,
    PortEast      = 2'd1,
    PortNorth     = 2'd2,
    PortNortheast = 2'd3
  } port_e;

endpackage

//--- tcdm_bank.sv
/*
 * TCDM bank: single-ported word memory behind a round-robin
 * arbiter over the local, east, north and northeast links
 */
`timescale 1ns/1ps

module tcdm_bank
  import cluster_pkg::*;
#(
  parameter int unsigned BankWords = 64
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  tcdm_req_t  [NumGroups-1:0]      req_i,
  input  logic       [NumGroups-1:0]      req_valid_i,
  output logic       [NumGroups-1:0]      req_ready_o,
  output tcdm_resp_t [NumGroups-1:0]      resp_o,
  output logic       [NumGroups-1:0]      resp_valid_o,
  input  logic       [NumGroups-1:0]      resp_ready_i
);

  localparam int unsigned RowWidth = $clog2(BankWords);

  logic [DataWidth-1:0] mem_q [BankWords];
  tcdm_resp_t           resp_q;
  logic                 resp_valid_q;
  port_e                resp_port_q;
  port_e                rr_q;
  port_e                winner;
  port_e                cand;
  logic                 any_valid;
  logic                 free;
  logic                 grant;
  tcdm_req_t            gnt_req;
  logic [RowWidth-1:0]  row;

  // Response register empty or leaving at this edge
  assign free  = !resp_valid_q || resp_ready_i[resp_port_q];
  assign grant = free && any_valid;

  always_comb begin
    winner    = rr_q;
    any_valid = 1'b0;
    for (int i = 0; i < NumGroups; i++) begin
      cand = port_e'(rr_q + 2'(i));
      if (!any_valid && req_valid_i[cand]) begin
        winner    = cand;
        any_valid = 1'b1;
      end
    end
    gnt_req = req_i[winner];
    row     = RowWidth'(gnt_req.addr[AddrWidth-1:2] % BankWords);
    req_ready_o         = '0;
    req_ready_o[winner] = grant;
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      resp_q.rdata <= mem_q[row];
      resp_q.wen   <= gnt_req.wen;
      resp_q.src   <= gnt_req.src;
      resp_q.tag   <= gnt_req.tag;
      if (gnt_req.wen) begin
        mem_q[row] <= gnt_req.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
      resp_port_q  <= PortLocal;
      rr_q         <= PortLocal;
    end else if (free) begin
      resp_valid_q <= any_valid;
      if (any_valid) begin
        resp_port_q <= winner;
        rr_q        <= port_e'(winner + 2'd1);
      end
    end
  end

  // Answer only on the link the request came in on
  always_comb begin
    for (int p = 0; p < NumGroups; p++) begin
      resp_o[p]       = resp_q;
      resp_valid_o[p] = resp_valid_q && (resp_port_q == port_e'(p));
    end
  end

endmodule

//--- tcdm_router.sv
/*
 * TCDM router: sends each core request down the link to its
 * target group and merges the four response links back to the core
 */
`timescale 1ns/1ps

module tcdm_router
  import cluster_pkg::*;
#(
  parameter group_id_t GroupId = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  tcdm_req_t                  core_req_i,
  input  logic                       core_req_valid_i,
  output logic                       core_req_ready_o,
  output tcdm_resp_t                 core_resp_o,
  output logic                       core_resp_valid_o,
  input  logic                       core_resp_ready_i,
  output tcdm_req_t  [NumGroups-1:0] req_o,
  output logic       [NumGroups-1:0] req_valid_o,
  input  logic       [NumGroups-1:0] req_ready_i,
  input  tcdm_resp_t [NumGroups-1:0] resp_i,
  input  logic       [NumGroups-1:0] resp_valid_i,
  output logic       [NumGroups-1:0] resp_ready_o
);

  port_e     route;
  tcdm_req_t req_stamped;
  port_e     rr_q;
  port_e     sel;
  port_e     sel_q;
  port_e     cand;
  logic      lock_q;
  logic      found;

  // Request path
  always_comb begin
    route           = port_e'(core_req_i.addr[1:0] ^ GroupId);
    req_stamped     = core_req_i;
    req_stamped.src = GroupId;
    for (int p = 0; p < NumGroups; p++) begin
      req_o[p]       = req_stamped;
      req_valid_o[p] = core_req_valid_i && (route == port_e'(p));
    end
  end

  assign core_req_ready_o = req_ready_i[route];

  // Response merge, held on one link while the core stalls
  always_comb begin
    sel   = rr_q;
    found = 1'b0;
    for (int i = 0; i < NumGroups; i++) begin
      cand = port_e'(rr_q + 2'(i));
      if (!found && resp_valid_i[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
    if (lock_q) begin
      sel = sel_q;
    end
    core_resp_o       = resp_i[sel];
    core_resp_valid_o = resp_valid_i[sel];
    resp_ready_o      = '0;
    resp_ready_o[sel] = core_resp_ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= PortLocal;
      sel_q  <= PortLocal;
      lock_q <= 1'b0;
    end else if (core_resp_valid_o && core_resp_ready_i) begin
      rr_q   <= port_e'(sel + 2'd1);
      lock_q <= 1'b0;
    end else if (core_resp_valid_o) begin
      sel_q  <= sel;
      lock_q <= 1'b1;
    end
  end

endmodule

//--- tcdm_bypass.sv
/*
 * Bypass slice: two-entry FIFOs that carry diagonal traffic,
 * requests toward the east neighbor and responses back north
 */
`timescale 1ns/1ps

module tcdm_bypass
  import cluster_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  tcdm_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output tcdm_req_t  req_o,
  output logic       req_valid_o,
  input  logic       req_ready_i,
  input  tcdm_resp_t resp_i,
  input  logic       resp_valid_i,
  output logic       resp_ready_o,
  output tcdm_resp_t resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i
);

  localparam int unsigned ReqW  = $bits(tcdm_req_t);
  localparam int unsigned RespW = $bits(tcdm_resp_t);

  // Channel 0 carries requests, channel 1 responses
  logic [1:0][ReqW-1:0] in_data;
  logic [1:0][ReqW-1:0] out_data;
  logic [1:0]           in_valid;
  logic [1:0]           in_ready;
  logic [1:0]           out_valid;
  logic [1:0]           out_ready;

  assign in_data[0]   = req_i;
  assign in_data[1]   = ReqW'(resp_i);
  assign in_valid     = {resp_valid_i, req_valid_i};
  assign out_ready    = {resp_ready_i, req_ready_i};
  assign req_ready_o  = in_ready[0];
  assign resp_ready_o = in_ready[1];
  assign req_o        = tcdm_req_t'(out_data[0]);
  assign req_valid_o  = out_valid[0];
  assign resp_o       = tcdm_resp_t'(out_data[1][RespW-1:0]);
  assign resp_valid_o = out_valid[1];

  for (genvar c = 0; c < 2; c++) begin : gen_chan
    logic [ReqW-1:0] mem_q [2];
    logic            wr_ptr_q;
    logic            rd_ptr_q;
    logic [1:0]      cnt_q;
    logic            push;
    logic            pop;

    assign in_ready[c]  = cnt_q != 2'd2;
    assign out_valid[c] = cnt_q != 2'd0;
    assign out_data[c]  = mem_q[rd_ptr_q];
    assign push         = in_valid[c] && in_ready[c];
    assign pop          = out_valid[c] && out_ready[c];

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= in_data[c];
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        wr_ptr_q <= 1'b0;
        rd_ptr_q <= 1'b0;
        cnt_q    <= 2'd0;
      end else begin
        wr_ptr_q <= wr_ptr_q ^ push;
        rd_ptr_q <= rd_ptr_q ^ pop;
        cnt_q    <= cnt_q + 2'(push) - 2'(pop);
      end
    end
  end

endmodule

//--- tcdm_group.sv
/*
 * TCDM group: router, bank and bypass slice, with the router's
 * local port tied straight to the bank
 */
`timescale 1ns/1ps

module tcdm_group
  import cluster_pkg::*;
#(
  parameter group_id_t   GroupId   = '0,
  parameter int unsigned BankWords = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  tcdm_req_t                    core_req_i,
  input  logic                         core_req_valid_i,
  output logic                         core_req_ready_o,
  output tcdm_resp_t                   core_resp_o,
  output logic                         core_resp_valid_o,
  input  logic                         core_resp_ready_i,
  // Outgoing east, north and northeast links, indexed by port_e
  output tcdm_req_t  [NumGroups-1:1]   mst_req_o,
  output logic       [NumGroups-1:1]   mst_req_valid_o,
  input  logic       [NumGroups-1:1]   mst_req_ready_i,
  input  tcdm_resp_t [NumGroups-1:1]   mst_resp_i,
  input  logic       [NumGroups-1:1]   mst_resp_valid_i,
  output logic       [NumGroups-1:1]   mst_resp_ready_o,
  // Incoming links into the bank
  input  tcdm_req_t  [NumGroups-1:1]   slv_req_i,
  input  logic       [NumGroups-1:1]   slv_req_valid_i,
  output logic       [NumGroups-1:1]   slv_req_ready_o,
  output tcdm_resp_t [NumGroups-1:1]   slv_resp_o,
  output logic       [NumGroups-1:1]   slv_resp_valid_o,
  input  logic       [NumGroups-1:1]   slv_resp_ready_i,
  // Bypass slice, toward the east neighbor
  output tcdm_req_t                    byp_mst_req_o,
  output logic                         byp_mst_req_valid_o,
  input  logic                         byp_mst_req_ready_i,
  input  tcdm_resp_t                   byp_mst_resp_i,
  input  logic                         byp_mst_resp_valid_i,
  output logic                         byp_mst_resp_ready_o,
  // Bypass slice, from the north neighbor
  input  tcdm_req_t                    byp_slv_req_i,
  input  logic                         byp_slv_req_valid_i,
  output logic                         byp_slv_req_ready_o,
  output tcdm_resp_t                   byp_slv_resp_o,
  output logic                         byp_slv_resp_valid_o,
  input  logic                         byp_slv_resp_ready_i
);

  tcdm_req_t  [NumGroups-1:0] rt_req;
  tcdm_req_t  [NumGroups-1:0] bk_req;
  tcdm_resp_t [NumGroups-1:0] rt_resp;
  tcdm_resp_t [NumGroups-1:0] bk_resp;
  logic       [NumGroups-1:0] rt_req_valid;
  logic       [NumGroups-1:0] rt_req_ready;
  logic       [NumGroups-1:0] rt_resp_valid;
  logic       [NumGroups-1:0] rt_resp_ready;
  logic       [NumGroups-1:0] bk_req_valid;
  logic       [NumGroups-1:0] bk_req_ready;
  logic       [NumGroups-1:0] bk_resp_valid;
  logic       [NumGroups-1:0] bk_resp_ready;

  // Router links: local goes to the bank, the rest leave the group
  assign mst_req_o        = rt_req[NumGroups-1:1];
  assign mst_req_valid_o  = rt_req_valid[NumGroups-1:1];
  assign mst_resp_ready_o = rt_resp_ready[NumGroups-1:1];
  assign rt_req_ready     = {mst_req_ready_i, bk_req_ready[PortLocal]};
  assign rt_resp          = {mst_resp_i, bk_resp[PortLocal]};
  assign rt_resp_valid    = {mst_resp_valid_i, bk_resp_valid[PortLocal]};

  // Bank links
  assign bk_req           = {slv_req_i, rt_req[PortLocal]};
  assign bk_req_valid     = {slv_req_valid_i, rt_req_valid[PortLocal]};
  assign bk_resp_ready    = {slv_resp_ready_i, rt_resp_ready[PortLocal]};
  assign slv_req_ready_o  = bk_req_ready[NumGroups-1:1];
  assign slv_resp_o       = bk_resp[NumGroups-1:1];
  assign slv_resp_valid_o = bk_resp_valid[NumGroups-1:1];

  tcdm_router #(
    .GroupId(GroupId)
  ) u_router (
    .clk_i,
    .rst_i,
    .core_req_i,
    .core_req_valid_i,
    .core_req_ready_o,
    .core_resp_o,
    .core_resp_valid_o,
    .core_resp_ready_i,
    .req_o       (rt_req),
    .req_valid_o (rt_req_valid),
    .req_ready_i (rt_req_ready),
    .resp_i      (rt_resp),
    .resp_valid_i(rt_resp_valid),
    .resp_ready_o(rt_resp_ready)
  );

  tcdm_bank #(
    .BankWords(BankWords)
  ) u_bank (
    .clk_i,
    .rst_i,
    .req_i       (bk_req),
    .req_valid_i (bk_req_valid),
    .req_ready_o (bk_req_ready),
    .resp_o      (bk_resp),
    .resp_valid_o(bk_resp_valid),
    .resp_ready_i(bk_resp_ready)
  );

  tcdm_bypass u_bypass (
    .clk_i,
    .rst_i,
    .req_i       (byp_slv_req_i),
    .req_valid_i (byp_slv_req_valid_i),
    .req_ready_o (byp_slv_req_ready_o),
    .req_o       (byp_mst_req_o),
    .req_valid_o (byp_mst_req_valid_o),
    .req_ready_i (byp_mst_req_ready_i),
    .resp_i      (byp_mst_resp_i),
    .resp_valid_i(byp_mst_resp_valid_i),
    .resp_ready_o(byp_mst_resp_ready_o),
    .resp_o      (byp_slv_resp_o),
    .resp_valid_o(byp_slv_resp_valid_o),
    .resp_ready_i(byp_slv_resp_ready_i)
  );

endmodule

//--- tcdm_cluster.sv
/*
 * TCDM cluster top: four groups joined by XOR-paired east and north
 * links, with northeast traffic routed through the north group's bypass
 */
`timescale 1ns/1ps

module tcdm_cluster
  import cluster_pkg::*;
#(
  parameter int unsigned BankWords = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  tcdm_req_t  [NumGroups-1:0] core_req_i,
  input  logic       [NumGroups-1:0] core_req_valid_i,
  output logic       [NumGroups-1:0] core_req_ready_o,
  output tcdm_resp_t [NumGroups-1:0] core_resp_o,
  output logic       [NumGroups-1:0] core_resp_valid_o,
  input  logic       [NumGroups-1:0] core_resp_ready_i
);

  // Nets driven by each group, indexed by the driving group
  tcdm_req_t  [NumGroups-1:1] mst_req          [NumGroups];
  logic       [NumGroups-1:1] mst_req_valid    [NumGroups];
  logic       [NumGroups-1:1] mst_resp_ready   [NumGroups];
  logic       [NumGroups-1:1] slv_req_ready    [NumGroups];
  tcdm_resp_t [NumGroups-1:1] slv_resp         [NumGroups];
  logic       [NumGroups-1:1] slv_resp_valid   [NumGroups];
  tcdm_req_t                  byp_mst_req      [NumGroups];
  logic                       byp_mst_req_valid[NumGroups];
  logic                       byp_mst_resp_ready[NumGroups];
  logic                       byp_slv_req_ready[NumGroups];
  tcdm_resp_t                 byp_slv_resp     [NumGroups];
  logic                       byp_slv_resp_valid[NumGroups];

  // Link order inside each concatenation is northeast, north, east
  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    tcdm_group #(
      .GroupId  (group_id_t'(g)),
      .BankWords(BankWords)
    ) u_group (
      .clk_i,
      .rst_i,
      .core_req_i          (core_req_i[g]),
      .core_req_valid_i    (core_req_valid_i[g]),
      .core_req_ready_o    (core_req_ready_o[g]),
      .core_resp_o         (core_resp_o[g]),
      .core_resp_valid_o   (core_resp_valid_o[g]),
      .core_resp_ready_i   (core_resp_ready_i[g]),
      .mst_req_o           (mst_req[g]),
      .mst_req_valid_o     (mst_req_valid[g]),
      .mst_req_ready_i     ({byp_slv_req_ready[g ^ 2], slv_req_ready[g ^ 2][PortNorth],
                             slv_req_ready[g ^ 1][PortEast]}),
      .mst_resp_i          ({byp_slv_resp[g ^ 2], slv_resp[g ^ 2][PortNorth],
                             slv_resp[g ^ 1][PortEast]}),
      .mst_resp_valid_i    ({byp_slv_resp_valid[g ^ 2], slv_resp_valid[g ^ 2][PortNorth],
                             slv_resp_valid[g ^ 1][PortEast]}),
      .mst_resp_ready_o    (mst_resp_ready[g]),
      .slv_req_i           ({byp_mst_req[g ^ 1], mst_req[g ^ 2][PortNorth],
                             mst_req[g ^ 1][PortEast]}),
      .slv_req_valid_i     ({byp_mst_req_valid[g ^ 1], mst_req_valid[g ^ 2][PortNorth],
                             mst_req_valid[g ^ 1][PortEast]}),
      .slv_req_ready_o     (slv_req_ready[g]),
      .slv_resp_o          (slv_resp[g]),
      .slv_resp_valid_o    (slv_resp_valid[g]),
      .slv_resp_ready_i    ({byp_mst_resp_ready[g ^ 1], mst_resp_ready[g ^ 2][PortNorth],
                             mst_resp_ready[g ^ 1][PortEast]}),
      // Bypass output feeds the east neighbor's northeast link
      .byp_mst_req_o       (byp_mst_req[g]),
      .byp_mst_req_valid_o (byp_mst_req_valid[g]),
      .byp_mst_req_ready_i (slv_req_ready[g ^ 1][PortNortheast]),
      .byp_mst_resp_i      (slv_resp[g ^ 1][PortNortheast]),
      .byp_mst_resp_valid_i(slv_resp_valid[g ^ 1][PortNortheast]),
      .byp_mst_resp_ready_o(byp_mst_resp_ready[g]),
      // Bypass input takes the north neighbor's northeast request
      .byp_slv_req_i       (mst_req[g ^ 2][PortNortheast]),
      .byp_slv_req_valid_i (mst_req_valid[g ^ 2][PortNortheast]),
      .byp_slv_req_ready_o (byp_slv_req_ready[g]),
      .byp_slv_resp_o      (byp_slv_resp[g]),
      .byp_slv_resp_valid_o(byp_slv_resp_valid[g]),
      .byp_slv_resp_ready_i(mst_resp_ready[g ^ 2][PortNortheast])
    );
  end : gen_groups

endmodule

//--- tcdm_cluster_properties.sv
/*
 * Handshake checks on the cluster's core request and response ports
 */
`timescale 1ns/1ps

module tcdm_cluster_properties
  import cluster_pkg::*;
(
  input logic                       clk_i,
  input logic                       rst_i,
  input tcdm_req_t  [NumGroups-1:0] core_req_i,
  input logic       [NumGroups-1:0] core_req_valid_i,
  input logic       [NumGroups-1:0] core_req_ready_o,
  input tcdm_resp_t [NumGroups-1:0] core_resp_o,
  input logic       [NumGroups-1:0] core_resp_valid_o,
  input logic       [NumGroups-1:0] core_resp_ready_i
);

  for (genvar g = 0; g < NumGroups; g++) begin : gen_ports
    req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      core_req_valid_i[g] && !core_req_ready_o[g]
      |=> core_req_valid_i[g] && $stable(core_req_i[g]))
      else $error("core %0d request dropped or changed while stalled", g);

    resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      core_resp_valid_o[g] && !core_resp_ready_i[g]
      |=> core_resp_valid_o[g] && $stable(core_resp_o[g]))
      else $error("core %0d response dropped or changed while stalled", g);
  end : gen_ports

  // Nothing may come back in the cycle after a reset edge
  resp_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> core_resp_valid_o == '0)
    else $error("core response valid high right after reset");

endmodule

//--- tb_tcdm_cluster.sv
/*
 * Testbench for the TCDM cluster: random traffic on all four core
 * ports, checked against a reference memory model by group and tag
 */
`timescale 1ns/1ps

module tb_tcdm_cluster
  import cluster_pkg::*;
();

  localparam int unsigned BankWords  = 64;
  localparam int unsigned RowWidth   = $clog2(BankWords);
  localparam int unsigned NumTags    = 1 << TagWidth;
  localparam int unsigned MaxOut     = 8;
  // One write per word of the group's own partition
  localparam int unsigned Phase1Ops  = BankWords;
  localparam int unsigned Phase2Ops  = 200;
  localparam int unsigned CycleLimit = 20 * NumGroups * (Phase1Ops + Phase2Ops);

  // Expected response, recorded when the request transfers
  typedef struct packed {
    logic                 busy;
    logic                 known;
    logic                 wen;
    logic                 diag;
    logic [DataWidth-1:0] data;
    logic [31:0]          cycle;
  } pending_t;

  logic                       clk = 1'b0;
  logic                       rst;
  tcdm_req_t  [NumGroups-1:0] core_req;
  logic       [NumGroups-1:0] core_req_valid;
  logic       [NumGroups-1:0] core_req_ready;
  tcdm_resp_t [NumGroups-1:0] core_resp;
  logic       [NumGroups-1:0] core_resp_valid;
  logic       [NumGroups-1:0] core_resp_ready;
  logic       [NumGroups-1:0] req_fired;

  logic [DataWidth-1:0] model_mem   [NumGroups*BankWords];
  logic                 model_known [NumGroups*BankWords];
  pending_t             pending     [NumGroups][NumTags];
  int unsigned          outstanding [NumGroups];
  int unsigned          ops_left    [NumGroups];
  int unsigned          sweep_idx   [NumGroups];
  int unsigned          phase;
  int unsigned          cycle;
  logic [31:0]          rand_state;

  tcdm_cluster #(
    .BankWords(BankWords)
  ) u_tcdm_cluster (
    .clk_i            (clk),
    .rst_i            (rst),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_resp_o      (core_resp),
    .core_resp_valid_o(core_resp_valid),
    .core_resp_ready_i(core_resp_ready)
  );

  bind tcdm_cluster tcdm_cluster_properties u_props (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  // Model word = bank row times group count plus bank
  function automatic int unsigned model_index(logic [AddrWidth-1:0] addr);
    return (((32'(addr) >> 2) % BankWords) * NumGroups) + 32'(addr[1:0]);
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic launch_request(int unsigned g);
    logic [31:0]          r;
    logic [TagWidth-1:0]  start;
    logic [TagWidth-1:0]  tag;
    logic [RowWidth-3:0]  low;
    logic [AddrWidth-1:0] addr;
    group_id_t            part;
    group_id_t            bank;
    logic                 wen;
    r     = next_rand();
    start = r[TagWidth-1:0];
    tag   = start;
    for (int k = NumTags - 1; k >= 0; k--) begin
      if (!pending[g][start + TagWidth'(k)].busy) begin
        tag = start + TagWidth'(k);
      end
    end
    if (phase == 1) begin
      wen  = 1'b1;
      part = group_id_t'(g);
      bank = group_id_t'(sweep_idx[g]);
      low  = (RowWidth-2)'(sweep_idx[g] >> 2);
      sweep_idx[g]++;
    end else begin
      wen  = r[4];
      bank = r[6:5];
      part = wen ? group_id_t'(g) : r[8:7];
      low  = r[RowWidth+6:9];
      // Writes stay in the lower half, foreign reads in the upper half
      if (wen) begin
        low[RowWidth-3] = 1'b0;
      end else if (part != group_id_t'(g)) begin
        low[RowWidth-3] = 1'b1;
      end
    end
    addr                 = AddrWidth'(next_rand());
    addr[RowWidth+1:2]   = {part, low};
    addr[1:0]            = bank;
    core_req[g].addr     = addr;
    core_req[g].wen      = wen;
    core_req[g].wdata    = next_rand();
    core_req[g].src      = r[11:10];
    core_req[g].tag      = tag;
    core_req_valid[g]    = 1'b1;
    ops_left[g]--;
  endtask

  task automatic record_issue(int unsigned g);
    tcdm_req_t           req;
    logic [TagWidth-1:0] t;
    int unsigned         idx;
    req = core_req[g];
    t   = req.tag;
    idx = model_index(req.addr);
    pending[g][t].busy  = 1'b1;
    pending[g][t].known = model_known[idx];
    pending[g][t].wen   = req.wen;
    pending[g][t].diag  = (req.addr[1:0] ^ group_id_t'(g)) == 2'd3;
    pending[g][t].data  = model_mem[idx];
    pending[g][t].cycle = cycle;
    outstanding[g]++;
    if (req.wen) begin
      model_mem[idx]   = req.wdata;
      model_known[idx] = 1'b1;
    end
  endtask

  task automatic check_response(int unsigned g);
    tcdm_resp_t          resp;
    pending_t            p;
    logic [TagWidth-1:0] t;
    resp = core_resp[g];
    t    = resp.tag;
    p    = pending[g][t];
    assert (p.busy) else begin
      $display("Group %0d got a response for tag %0d that was never issued", g, t);
      abort_run();
    end
    assert (resp.src == group_id_t'(g)) else begin
      $display("ERR core_resp_o[%0d].src tag %0d: got %h, expected %h", g, t, resp.src, g);
      abort_run();
    end
    assert (resp.wen == p.wen) else begin
      $display("ERR core_resp_o[%0d].wen tag %0d: got %h, expected %h", g, t, resp.wen, p.wen);
      abort_run();
    end
    assert (!p.known || resp.rdata == p.data) else begin
      $display("ERR core_resp_o[%0d].rdata tag %0d: got %h, expected %h",
               g, t, resp.rdata, p.data);
      abort_run();
    end
    assert (!p.diag || cycle - p.cycle >= 3) else begin
      $display("Northeast response on group %0d tag %0d arrived after only %0d cycles",
               g, t, cycle - p.cycle);
      abort_run();
    end
    pending[g][t].busy = 1'b0;
    outstanding[g]--;
  endtask

  // Sampled at the falling edge, where all DUT outputs have settled
  task automatic sample_cycle();
    if (phase == 0) begin
      assert (core_resp_valid == '0) else begin
        $display("ERR core_resp_valid_o: got %h, expected 0", core_resp_valid);
        abort_run();
      end
    end
    for (int unsigned g = 0; g < NumGroups; g++) begin
      if (core_resp_valid[g] && core_resp_ready[g]) begin
        check_response(g);
      end
    end
    for (int unsigned g = 0; g < NumGroups; g++) begin
      if (core_req_valid[g] && core_req_ready[g]) begin
        record_issue(g);
        req_fired[g] = 1'b1;
      end
    end
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      if (req_fired[g]) begin
        core_req_valid[g] = 1'b0;
      end
      r = next_rand();
      if (!core_req_valid[g] && phase != 0 && ops_left[g] != 0 &&
          outstanding[g] < MaxOut && r[1:0] != 2'd0) begin
        launch_request(g);
      end
      core_resp_ready[g] = r[3:2] != 2'd0;
    end
    req_fired = '0;
  endtask

  task automatic run_phase(int unsigned p, int unsigned n);
    logic busy;
    @(posedge clk);
    for (int unsigned g = 0; g < NumGroups; g++) begin
      ops_left[g] = n;
    end
    phase = p;
    do begin
      @(posedge clk);
      busy = 1'b0;
      for (int unsigned g = 0; g < NumGroups; g++) begin
        if (ops_left[g] != 0 || core_req_valid[g] || outstanding[g] != 0) begin
          busy = 1'b1;
        end
      end
    end while (busy);
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (!rst) begin
        sample_cycle();
      end
      @(posedge clk);
      cycle++;
      assert (cycle < CycleLimit) else begin
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        abort_run();
      end
      #2;
      drive_cycle();
    end
  end

  initial begin
    rand_state      = 32'hc29b;
    rst             = 1'b1;
    core_req        = '0;
    core_req_valid  = '0;
    core_resp_ready = '0;
    req_fired       = '0;
    phase           = 0;
    cycle           = 0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      outstanding[g] = 0;
      ops_left[g]    = 0;
      sweep_idx[g]   = 0;
      for (int unsigned t = 0; t < NumTags; t++) begin
        pending[g][t] = '0;
      end
    end
    for (int unsigned i = 0; i < NumGroups * BankWords; i++) begin
      model_mem[i]   = '0;
      model_known[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    // Idle cycles, no response may appear
    repeat (4) @(posedge clk);
    run_phase(1, Phase1Ops);
    run_phase(2, Phase2Ops);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- flist.f
cluster_pkg.sv
tcdm_bank.sv
tcdm_router.sv
tcdm_bypass.sv
tcdm_group.sv
tcdm_cluster.sv
tcdm_cluster_properties.sv
tb_tcdm_cluster.sv

//--- Makefile
TOP := tb_tcdm_cluster

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
